//--- source/msgq_pkg.sv
package msgq_pkg;

	// Message word width
	localparam int DATA_BITS = 32;

	// Each ring is a power of two deep so the pointers wrap for free
	localparam int RING_DEPTH_BITS = 8;
	localparam int RING_DEPTH = 1 << RING_DEPTH_BITS;

	// One ring per direction
	localparam int NUM_RINGS = 2;

	// Top address bit selects the ring
	localparam int MEM_ADDR_BITS = RING_DEPTH_BITS + 1;

	typedef logic [DATA_BITS-1:0] msg_word_t;
	typedef logic [RING_DEPTH_BITS-1:0] ring_ptr_t;
	typedef logic [RING_DEPTH_BITS:0] ring_count_t;   // 0 to RING_DEPTH inclusive
	typedef logic [MEM_ADDR_BITS-1:0] mem_addr_t;

	// Memory request opcode
	typedef enum logic {
		MEM_WRITE = 1'b0,
		MEM_READ  = 1'b1
	} mem_op_e;

	// Host register select, code 3 is unused
	typedef enum logic [1:0] {
		REG_DATA    = 2'd0,
		REG_STATUS  = 2'd1,
		REG_CONTROL = 2'd2
	} host_reg_e;

	// Ring index names
	typedef enum logic {
		DIR_TO_CLIENT = 1'b0,   // Ring 0, host to client
		DIR_TO_HOST   = 1'b1    // Ring 1, client to host
	} ring_dir_e;

endpackage

//--- source/msgq_mem_if.sv
`timescale 1ns/100ps

// Request and response path between one ring controller and the arbiter
interface msgq_mem_if import msgq_pkg::*; ();

	logic req;         // Held until grant
	mem_op_e op;
	mem_addr_t addr;
	msg_word_t wdata;

	logic grant;       // One-cycle accept
	msg_word_t rdata;
	logic rvalid;      // Two cycles after a read grant

	modport ring (
		output req, op, addr, wdata,
		input grant, rdata, rvalid
	);

	modport arb (
		input req, op, addr, wdata,
		output grant, rdata, rvalid
	);

endinterface

//--- source/msgq_ring_if.sv
`timescale 1ns/100ps

// Strobe path between the endpoint router and one ring controller
interface msgq_ring_if import msgq_pkg::*; ();

	logic push;
	msg_word_t push_data;
	logic pop;

	logic ready;             // Low while a memory request is pending
	msg_word_t pop_data;
	logic pop_valid;         // One-cycle pulse with pop_data
	ring_count_t count;
	logic overflow;          // Sticky until cleared through control

	modport endpoint (
		output push, push_data, pop,
		input ready, pop_data, pop_valid, count, overflow
	);

	modport ring (
		input push, push_data, pop,
		output ready, pop_data, pop_valid, count, overflow
	);

endinterface

//--- source/msgq_endpoints.sv
`timescale 1ns/100ps

module msgq_endpoints import msgq_pkg::*; (
	input logic clk,
	input logic reset,

	// Host register port
	input logic host_wr,
	input logic host_rd,
	input host_reg_e host_addr,
	input msg_word_t host_wdata,
	output msg_word_t host_rdata,
	output logic host_rvalid,
	output logic host_ready,

	// Client port
	input logic client_push,
	input msg_word_t client_wdata,
	input logic client_pop,
	output msg_word_t client_rdata,
	output logic client_rvalid,
	output logic client_ready,

	output logic irq,
	output logic clear_overflow,   // Pulse to both rings

	msgq_ring_if.endpoint rings [NUM_RINGS]
);

	logic irq_en;
	logic reg_rvalid;
	msg_word_t reg_rdata;
	msg_word_t status_word;
	logic host_data_wr;
	logic host_data_rd;

	assign host_data_wr = host_wr && (host_addr == REG_DATA);
	assign host_data_rd = host_rd && (host_addr == REG_DATA);

	// Ring 0 carries host writes to the client
	assign rings[0].push = host_data_wr;
	assign rings[0].push_data = host_wdata;
	assign rings[0].pop = client_pop;

	// Ring 1 carries client pushes to the host
	assign rings[1].push = client_push;
	assign rings[1].push_data = client_wdata;
	assign rings[1].pop = host_data_rd;

	// Both sides touch both rings, so both must be free
	assign host_ready = rings[0].ready & rings[1].ready;
	assign client_ready = rings[0].ready & rings[1].ready;

	assign clear_overflow = host_wr && (host_addr == REG_CONTROL) && host_wdata[1];

	always_comb begin
		status_word = '0;
		status_word[8:0] = rings[0].count;
		status_word[24:16] = rings[1].count;
		status_word[30] = rings[0].overflow;
		status_word[31] = rings[1].overflow;
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			irq_en <= 1'b0;
			reg_rvalid <= 1'b0;
			irq <= 1'b0;
		end else begin
			if (host_wr && (host_addr == REG_CONTROL))
				irq_en <= host_wdata[0];   // Bit 1 is a strobe only
			reg_rvalid <= host_rd && (host_addr != REG_DATA);
			// Pending messages for the host, or any lost word
			irq <= irq_en && ((rings[1].count != '0) || rings[0].overflow || rings[1].overflow);
		end
	end

	// Register read data, address 3 reads as zero
	always_ff @(posedge clk) begin
		if (host_rd) begin
			case (host_addr)
				REG_STATUS: reg_rdata <= status_word;
				REG_CONTROL: reg_rdata <= {{(DATA_BITS-1){1'b0}}, irq_en};
				default: reg_rdata <= '0;
			endcase
		end
	end

	// Popped ring 1 data takes the host return path ahead of a register read
	assign host_rvalid = rings[1].pop_valid | reg_rvalid;
	assign host_rdata = rings[1].pop_valid ? rings[1].pop_data : reg_rdata;

	assign client_rvalid = rings[0].pop_valid;
	assign client_rdata = rings[0].pop_data;

endmodule

//--- source/msgq_ring.sv
`timescale 1ns/100ps

module msgq_ring import msgq_pkg::*; (
	input logic clk,
	input logic reset,
	input ring_dir_e ring_index,   // Upper SRAM address bit
	msgq_ring_if.ring ring,
	msgq_mem_if.ring mem,
	input logic clear_overflow
);

	ring_ptr_t head;          // Next word to pop
	ring_ptr_t tail;          // Next free slot
	ring_count_t count;
	logic overflow;

	// Single outstanding memory request
	logic pending;
	mem_op_e pend_op;
	mem_addr_t pend_addr;
	msg_word_t pend_wdata;

	logic full;
	logic empty;
	logic push_ok;
	logic pop_ok;

	assign full = (count == ring_count_t'(RING_DEPTH));
	assign empty = (count == '0);

	// A push in the same cycle as a pop wins the request slot
	assign push_ok = ring.push && !pending && !full;
	assign pop_ok = ring.pop && !ring.push && !pending && !empty;

	always_ff @(posedge clk) begin
		if (reset) begin
			head <= '0;
			tail <= '0;
			count <= '0;
			overflow <= 1'b0;
			pending <= 1'b0;
		end else begin
			if (push_ok) begin
				tail <= tail + 1'b1;
				count <= count + 1'b1;
				pending <= 1'b1;
			end else if (pop_ok) begin
				head <= head + 1'b1;
				count <= count - 1'b1;
				pending <= 1'b1;
			end else if (mem.grant) begin
				pending <= 1'b0;
			end

			if (clear_overflow)
				overflow <= 1'b0;
			else if (ring.push && !pending && full)
				overflow <= 1'b1;   // Word is dropped
		end
	end

	// Request payload, captured with the accepted strobe
	always_ff @(posedge clk) begin
		if (push_ok) begin
			pend_op <= MEM_WRITE;
			pend_addr <= {ring_index, tail};
			pend_wdata <= ring.push_data;
		end else if (pop_ok) begin
			pend_op <= MEM_READ;
			pend_addr <= {ring_index, head};
		end
	end

	assign mem.req = pending;
	assign mem.op = pend_op;
	assign mem.addr = pend_addr;
	assign mem.wdata = pend_wdata;

	// Read returns go straight back to the endpoint
	assign ring.pop_valid = mem.rvalid;
	assign ring.pop_data = mem.rdata;

	assign ring.ready = !pending;
	assign ring.count = count;
	assign ring.overflow = overflow;

endmodule

//--- source/msgq_mem_arbiter.sv
`timescale 1ns/100ps

module msgq_mem_arbiter import msgq_pkg::*; (
	input logic clk,
	input logic reset,
	msgq_mem_if.arb mem [NUM_RINGS],
	output logic sram_en,
	output logic sram_we,
	output mem_addr_t sram_addr,
	output msg_word_t sram_wdata,
	input msg_word_t sram_rdata
);

	logic [NUM_RINGS-1:0] req_vec;
	logic [NUM_RINGS-1:0] grant_vec;
	logic [NUM_RINGS-1:0] rvalid_vec;
	mem_op_e op_arr [NUM_RINGS];
	mem_addr_t addr_arr [NUM_RINGS];
	msg_word_t wdata_arr [NUM_RINGS];

	ring_dir_e prio;          // Ring that wins a tie
	ring_dir_e winner;
	logic any_req;

	// Read tag pipeline, stage 1 lines up with SRAM data, stage 2 with rdata_q
	logic tag1_valid;
	logic tag2_valid;
	ring_dir_e tag1_ring;
	ring_dir_e tag2_ring;
	msg_word_t rdata_q;

	for (genvar i = 0; i < NUM_RINGS; i++) begin : g_port
		assign req_vec[i] = mem[i].req;
		assign op_arr[i] = mem[i].op;
		assign addr_arr[i] = mem[i].addr;
		assign wdata_arr[i] = mem[i].wdata;
		assign mem[i].grant = grant_vec[i];
		assign mem[i].rdata = rdata_q;
		assign rvalid_vec[i] = tag2_valid && (tag2_ring == ring_dir_e'(i));
		assign mem[i].rvalid = rvalid_vec[i];
	end

	always_comb begin
		any_req = |req_vec;
		winner = req_vec[prio] ? prio : ring_dir_e'(~prio);
		grant_vec = '0;
		if (any_req)
			grant_vec[winner] = 1'b1;
	end

	assign sram_en = any_req;
	assign sram_we = any_req && (op_arr[winner] == MEM_WRITE);
	assign sram_addr = addr_arr[winner];
	assign sram_wdata = wdata_arr[winner];

	always_ff @(posedge clk) begin
		if (reset) begin
			prio <= DIR_TO_CLIENT;
			tag1_valid <= 1'b0;
			tag2_valid <= 1'b0;
		end else begin
			if (any_req)
				prio <= ring_dir_e'(~winner);   // Loser of this round goes first next
			tag1_valid <= any_req && (op_arr[winner] == MEM_READ);
			tag2_valid <= tag1_valid;
		end
	end

	always_ff @(posedge clk) begin
		tag1_ring <= winner;
		tag2_ring <= tag1_ring;
		rdata_q <= sram_rdata;
	end

endmodule

//--- source/msgq_sram.sv
`timescale 1ns/100ps

// Single-port message store, both rings side by side
module msgq_sram import msgq_pkg::*; (
	input logic clk,
	input logic en,
	input logic we,
	input mem_addr_t addr,
	input msg_word_t wdata,
	output msg_word_t rdata
);

	msg_word_t mem [NUM_RINGS * RING_DEPTH];

	always_ff @(posedge clk) begin
		if (en) begin
			if (we)
				mem[addr] <= wdata;
			else
				rdata <= mem[addr];   // Valid one cycle after the read
		end
	end

endmodule

//--- source/bidi_message_queue.sv
`timescale 1ns/100ps

module bidi_message_queue import msgq_pkg::*; (
	input logic clk,
	input logic reset,

	input logic host_wr,
	input logic host_rd,
	input host_reg_e host_addr,
	input msg_word_t host_wdata,
	output msg_word_t host_rdata,
	output logic host_rvalid,
	output logic host_ready,

	input logic client_push,
	input msg_word_t client_wdata,
	input logic client_pop,
	output msg_word_t client_rdata,
	output logic client_rvalid,
	output logic client_ready,

	output logic irq
);

	logic clear_overflow;
	logic sram_en;
	logic sram_we;
	mem_addr_t sram_addr;
	msg_word_t sram_wdata;
	msg_word_t sram_rdata;

	msgq_ring_if u_ring_if [NUM_RINGS] ();
	msgq_mem_if u_mem_if [NUM_RINGS] ();

	msgq_endpoints u_endpoints (
		.clk (clk),
		.reset (reset),
		.host_wr (host_wr),
		.host_rd (host_rd),
		.host_addr (host_addr),
		.host_wdata (host_wdata),
		.host_rdata (host_rdata),
		.host_rvalid (host_rvalid),
		.host_ready (host_ready),
		.client_push (client_push),
		.client_wdata (client_wdata),
		.client_pop (client_pop),
		.client_rdata (client_rdata),
		.client_rvalid (client_rvalid),
		.client_ready (client_ready),
		.irq (irq),
		.clear_overflow (clear_overflow),
		.rings (u_ring_if)
	);

	for (genvar i = 0; i < NUM_RINGS; i++) begin : g_ring
		msgq_ring u_ring (
			.clk (clk),
			.reset (reset),
			.ring_index (ring_dir_e'(i)),
			.ring (u_ring_if[i].ring),
			.mem (u_mem_if[i].ring),
			.clear_overflow (clear_overflow)
		);
	end

	msgq_mem_arbiter u_mem_arbiter (
		.clk (clk),
		.reset (reset),
		.mem (u_mem_if),
		.sram_en (sram_en),
		.sram_we (sram_we),
		.sram_addr (sram_addr),
		.sram_wdata (sram_wdata),
		.sram_rdata (sram_rdata)
	);

	msgq_sram u_sram (
		.clk (clk),
		.en (sram_en),
		.we (sram_we),
		.addr (sram_addr),
		.wdata (sram_wdata),
		.rdata (sram_rdata)
	);

endmodule

//--- include/msgq_tb_tasks.svh
`ifndef MSGQ_TB_TASKS_SVH
`define MSGQ_TB_TASKS_SVH

msg_word_t q_to_client [$];   // Expected ring 0 contents
msg_word_t q_to_host [$];     // Expected ring 1 contents

task automatic report_failure(input string what);
	error_count++;
	$display("At %0t: %s", $time, what);
endtask

task automatic compare_word(input string name, input msg_word_t exp, input msg_word_t act);
	check_count++;
	if (exp !== act) begin
		error_count++;
		$display("ERROR at %0t: %s expected %h, got %h", $time, name, exp, act);
	end
endtask

task automatic compare_count(input string name, input ring_count_t exp, input ring_count_t act);
	check_count++;
	if (exp !== act) begin
		error_count++;
		$display("ERROR at %0t: %s expected %0d, got %0d", $time, name, exp, act);
	end
endtask

task automatic compare_bit(input string name, input logic exp, input logic act);
	check_count++;
	if (exp !== act) begin
		error_count++;
		$display("ERROR at %0t: %s expected %b, got %b", $time, name, exp, act);
	end
endtask

// All drivers start and end on a falling edge
task automatic wait_ready();
	int n = 0;
	while (!(host_ready && client_ready) && n < 16) begin
		@(negedge clk);
		n++;
	end
	if (!(host_ready && client_ready))
		report_failure("ready stayed low for 16 cycles");
endtask

task automatic host_write(input host_reg_e addr, input msg_word_t data);
	wait_ready();
	host_wr = 1'b1;
	host_addr = addr;
	host_wdata = data;
	@(negedge clk);
	host_wr = 1'b0;
endtask

task automatic client_write(input msg_word_t data);
	wait_ready();
	client_push = 1'b1;
	client_wdata = data;
	@(negedge clk);
	client_push = 1'b0;
endtask

task automatic wait_rvalid(input bit host_side, output msg_word_t data, output bit seen);
	seen = 1'b0;
	data = '0;
	for (int n = 0; n < 16 && !seen; n++) begin
		if (host_side ? host_rvalid : client_rvalid) begin
			seen = 1'b1;
			data = host_side ? host_rdata : client_rdata;
		end else begin
			@(negedge clk);
		end
	end
endtask

task automatic host_read(input host_reg_e addr, output msg_word_t data, output bit seen);
	wait_ready();
	host_rd = 1'b1;
	host_addr = addr;
	@(negedge clk);
	host_rd = 1'b0;
	wait_rvalid(1'b1, data, seen);
endtask

task automatic client_read(output msg_word_t data, output bit seen);
	wait_ready();
	client_pop = 1'b1;
	@(negedge clk);
	client_pop = 1'b0;
	wait_rvalid(1'b0, data, seen);
endtask

task automatic read_reg(input host_reg_e addr, output msg_word_t data);
	bit seen;
	host_read(addr, data, seen);
	if (!seen)
		report_failure("no host_rvalid within 16 cycles of a register read");
endtask

task automatic push_from_host(input msg_word_t w);
	q_to_client.push_back(w);
	host_write(REG_DATA, w);
endtask

task automatic push_from_client(input msg_word_t w);
	q_to_host.push_back(w);
	client_write(w);
endtask

task automatic pop_client_check();
	msg_word_t exp;
	msg_word_t data;
	bit seen;
	exp = q_to_client.pop_front();
	client_read(data, seen);
	if (!seen)
		report_failure("no client_rvalid within 16 cycles of a pop");
	else
		compare_word("client_rdata", exp, data);
endtask

task automatic read_host_check();
	msg_word_t exp;
	msg_word_t data;
	bit seen;
	exp = q_to_host.pop_front();
	host_read(REG_DATA, data, seen);
	if (!seen)
		report_failure("no host_rvalid within 16 cycles of a data read");
	else
		compare_word("host_rdata", exp, data);
endtask

task automatic check_status(input ring_count_t cnt0, input ring_count_t cnt1,
		input logic ov0, input logic ov1);
	msg_word_t status;
	read_reg(REG_STATUS, status);
	compare_count("status ring 0 count", cnt0, status[8:0]);
	compare_count("status ring 1 count", cnt1, status[24:16]);
	compare_bit("status ring 0 overflow", ov0, status[30]);
	compare_bit("status ring 1 overflow", ov1, status[31]);
	compare_word("status unused bits", '0, status & 32'h3e00_fe00);
endtask

// irq follows its cause one cycle later
task automatic check_irq(input logic exp);
	repeat (2) @(negedge clk);
	compare_bit("irq", exp, irq);
endtask

task automatic test_reset_state();
	msg_word_t data;
	compare_bit("irq", 1'b0, irq);
	compare_bit("host_ready", 1'b1, host_ready);
	compare_bit("client_ready", 1'b1, client_ready);
	check_status('0, '0, 1'b0, 1'b0);
	read_reg(REG_CONTROL, data);
	compare_word("control", '0, data);
endtask

task automatic test_host_to_client();
	repeat (40) push_from_host($urandom);
	check_status(9'd40, '0, 1'b0, 1'b0);
	repeat (40) pop_client_check();
endtask

task automatic test_client_to_host();
	host_write(REG_CONTROL, 32'h1);
	repeat (5) push_from_client($urandom);
	check_status('0, 9'd5, 1'b0, 1'b0);
	check_irq(1'b1);
	repeat (5) read_host_check();
	check_irq(1'b0);
	host_write(REG_CONTROL, 32'h0);   // Interrupt masked
	push_from_client($urandom);
	check_irq(1'b0);
	read_host_check();
endtask

task automatic test_interleaved();
	int op;
	for (int i = 0; i < 200; i++) begin
		op = int'($urandom % 4);
		if (op == 2 && q_to_client.size() == 0)
			op = 0;   // Nothing to pop yet
		if (op == 3 && q_to_host.size() == 0)
			op = 1;
		case (op)
			0: push_from_host($urandom);
			1: push_from_client($urandom);
			2: pop_client_check();
			default: read_host_check();
		endcase
	end
	check_status(ring_count_t'(q_to_client.size()), ring_count_t'(q_to_host.size()), 1'b0, 1'b0);
	while (q_to_client.size() > 0)
		pop_client_check();
	while (q_to_host.size() > 0)
		read_host_check();
endtask

task automatic test_overflow();
	msg_word_t w;
	host_write(REG_CONTROL, 32'h1);
	for (int i = 0; i <= RING_DEPTH; i++) begin
		w = $urandom;
		if (i < RING_DEPTH)
			q_to_client.push_back(w);   // Last word is lost
		host_write(REG_DATA, w);
	end
	check_status(ring_count_t'(RING_DEPTH), '0, 1'b1, 1'b0);
	check_irq(1'b1);
	repeat (RING_DEPTH) pop_client_check();
	check_status('0, '0, 1'b1, 1'b0);   // Flag is sticky
	host_write(REG_CONTROL, 32'h2);     // Clear flags, enable off
	check_status('0, '0, 1'b0, 1'b0);
	check_irq(1'b0);
endtask

task automatic test_underflow();
	msg_word_t data;
	bit seen;
	check_status('0, '0, 1'b0, 1'b0);
	client_read(data, seen);
	if (seen)
		report_failure("client_rvalid seen after a pop on an empty ring");
	host_read(REG_DATA, data, seen);
	if (seen)
		report_failure("host_rvalid seen after a data read on an empty ring");
	check_status('0, '0, 1'b0, 1'b0);   // Counts stay at zero, flags untouched
endtask

`endif

//--- sim/bidi_message_queue_tb.sv
`timescale 1ns/100ps

module bidi_message_queue_tb import msgq_pkg::*; ();

	localparam int CLK_PERIOD = 4;
	localparam int RESET_CYCLES = 16;
	localparam logic [31:0] SEED = 32'h5d74_5f9e;
	// Upper bound on words pushed over all tests, each allowed 10 cycles
	localparam int WORDS_PUSHED = 40 + 6 + 200 + 257;
	localparam int WATCHDOG_CYCLES = WORDS_PUSHED * 10 + 2000;

	logic clk;
	logic reset;
	logic host_wr;
	logic host_rd;
	host_reg_e host_addr;
	msg_word_t host_wdata;
	msg_word_t host_rdata;
	logic host_rvalid;
	logic host_ready;
	logic client_push;
	msg_word_t client_wdata;
	logic client_pop;
	msg_word_t client_rdata;
	logic client_rvalid;
	logic client_ready;
	logic irq;

	int error_count = 0;
	int check_count = 0;
	int tests_run = 0;
	int errors_before = 0;

	bidi_message_queue u_bidi_message_queue (
		.clk (clk),
		.reset (reset),
		.host_wr (host_wr),
		.host_rd (host_rd),
		.host_addr (host_addr),
		.host_wdata (host_wdata),
		.host_rdata (host_rdata),
		.host_rvalid (host_rvalid),
		.host_ready (host_ready),
		.client_push (client_push),
		.client_wdata (client_wdata),
		.client_pop (client_pop),
		.client_rdata (client_rdata),
		.client_rvalid (client_rvalid),
		.client_ready (client_ready),
		.irq (irq)
	);

	`include "msgq_tb_tasks.svh"

	always #(CLK_PERIOD / 2) clk = ~clk;

	task automatic finish_test(input string name);
		tests_run++;
		$display("Test %0d (%s) done with %0d errors", tests_run, name, error_count - errors_before);
		errors_before = error_count;
	endtask

	initial begin
		clk = 1'b0;
		reset = 1'b1;
		host_wr = 1'b0;
		host_rd = 1'b0;
		host_addr = REG_DATA;
		host_wdata = '0;
		client_push = 1'b0;
		client_wdata = '0;
		client_pop = 1'b0;
		void'($urandom(SEED));
		repeat (RESET_CYCLES) @(negedge clk);
		reset = 1'b0;
		@(negedge clk);
		test_reset_state();
		finish_test("reset state");
		test_host_to_client();
		finish_test("host to client");
		test_client_to_host();
		finish_test("client to host with irq");
		test_interleaved();
		finish_test("interleaved traffic");
		test_overflow();
		finish_test("overflow");
		test_underflow();
		finish_test("underflow");
		$display("%0d tests, %0d checks, %0d errors", tests_run, check_count, error_count);
		if (error_count == 0)
			$display("NO ERRORS");
		else
			$display("ERRORS FOUND");
		$finish;
	end

	// Hard stop if the sequence hangs
	initial begin
		#(WATCHDOG_CYCLES * CLK_PERIOD);
		$display("Watchdog expired after %0d cycles, the tests did not finish", WATCHDOG_CYCLES);
		$display("ERRORS FOUND");
		$finish;
	end

endmodule

//--- compile.f
+incdir+include
source/msgq_pkg.sv
source/msgq_mem_if.sv
source/msgq_ring_if.sv
source/msgq_endpoints.sv
source/msgq_ring.sv
source/msgq_mem_arbiter.sv
source/msgq_sram.sv
source/bidi_message_queue.sv
sim/bidi_message_queue_tb.sv

//--- Makefile
# Verilator build and run for the bidirectional message queue

VERILATOR ?= verilator
TOP ?= bidi_message_queue_tb
SEED_ARGS ?= +verilator+seed+1
LOG ?= sim.log
OBJ_DIR ?= obj_dir
VFLAGS ?= --binary --timing -Wno-fatal

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f compile.f
	./$(OBJ_DIR)/V$(TOP) $(SEED_ARGS) > $(LOG) 2>&1 || true
	cat $(LOG)
	@if grep -q "ERRORS FOUND" $(LOG) || ! grep -q "NO ERRORS" $(LOG); then \
		echo "Simulation failed, see $(LOG)"; \
		exit 1; \
	fi
	@echo "Simulation passed"

clean:
	rm -rf $(OBJ_DIR) $(LOG)
